// File: Makefile
# Verilator build and run of the SKIROC2 slow-control testbench
TOP := tb_skiroc_sc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/1ns \
		-f files.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dv/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * Free-running system clock and a synchronous active-low reset that
 * is held for a few clock cycles at the start of the run.
 */
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD_NS  = 4,
	parameter int RST_CYCLES = 2
) (
	output logic Clk_Out_2_All,
	output logic rst_n_o
);

	initial
	begin
		Clk_Out_2_All = 1'b0;
		forever
			#(PERIOD_NS / 2) Clk_Out_2_All = ~Clk_Out_2_All;
	end

	// Release just after an edge, like the rest of the stimulus
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge Clk_Out_2_All);
		#1 rst_n_o = 1'b1;
	end

endmodule

// File: dv/tb_skiroc_sc.sv
/*
 * SKIROC2 slow-control testbench
 * Writes configuration fields as command words, keeps a model of the
 * configuration and rebuilds the expected frame from it. The serial
 * bits are captured on the rising serial clock and each frame is
 * compared when sc_done_o pulses.
 */
`timescale 1ns/1ns

module tb_skiroc_sc;

	import sc_cmd_pkg::*;
	import sc_frame_pkg::*;

	localparam int FRAME_TIMEOUT = 3000;   // Cycles, a frame takes about 650
	localparam int RST_TIMEOUT   = 20;

	logic         Clk_Out_2_All;
	logic         rst_n;
	logic [15:0]  cmd_word;
	logic         cmd_valid;
	logic         sr_ck;
	logic         sr_in;
	logic         sc_busy;
	logic         sc_done;

	// Configuration model, same reset as the chip
	logic [9:0]   m_thr;
	logic [9:0]   m_gain;
	logic [63:0]  m_mask;
	logic [3:0]   m_fbcap;
	logic         m_tdc;
	logic         m_adc;
	logic [7:0]   m_chip;

	logic [103:0] exp_q [$];   // Expected frames, oldest first
	logic [103:0] cap_q [$];   // Captured at each sc_done_o
	int           cnt_q [$];   // Serial clock rises per captured frame
	int           frames_checked;
	logic [103:0] cap_frame;
	int           cap_cnt;
	logic         ck_prev;
	logic         busy_prev;
	logic         done_prev;

	tb_clk_gen u_clk_gen (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_o       (rst_n)
	);

	skiroc_sc_top u_dut (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n),
		.cmd_i         (cmd_word),
		.cmd_valid_i   (cmd_valid),
		.sr_ck_o       (sr_ck),
		.sr_in_o       (sr_in),
		.sc_busy_o     (sc_busy),
		.sc_done_o     (sc_done)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [127:0] got,
			input logic [127:0] want);
		if (got !== want)
			abort_run($sformatf("ERR at %0t ns: %s got %0h, expected %0h",
				$time, name, got, want));
	endtask

	// Expected frame, chip ID on top, six pad zeros at the bottom
	function automatic logic [103:0] ref_frame();
		return {m_chip, m_mask, m_thr, m_gain, m_fbcap, m_tdc, m_adc, 6'b000000};
	endfunction

	function automatic void model_write(input logic [3:0] op, input logic [11:0] pay);
		int idx;
		idx = int'(pay[10:8]);   // Mask byte index, 0 is bits 7..0
		case (op)
			OPC_THR_DAC:   m_thr   = pay[9:0];
			OPC_GAIN_DAC:  m_gain  = pay[9:0];
			OPC_MASK_BYTE: m_mask[idx*8 +: 8] = pay[7:0];
			OPC_FB_CAP:    m_fbcap = pay[3:0];
			OPC_FLAGS:
			begin
				m_tdc = pay[1];
				m_adc = pay[0];
			end
			OPC_CHIP_ID:   m_chip  = pay[7:0];
			default:       ;   // Start and reserved opcodes
		endcase
	endfunction

	// Zero or one of 7..14
	function automatic logic [3:0] unknown_opcode();
		int v;
		v = int'($urandom_range(0, 8));
		if (v == 0)
			return 4'd0;
		return 4'(6 + v);
	endfunction

	task automatic step();
		@(posedge Clk_Out_2_All);
		#1;
	endtask

	task automatic send_cmd(input logic [3:0] op, input logic [11:0] pay);
		model_write(op, pay);
		cmd_word  = {op, pay};
		cmd_valid = 1'b1;
		step();
		cmd_valid = 1'b0;   // Back to back calls keep the strobe up
	endtask

	// Start while idle, busy must show two cycles after the strobe
	task automatic send_start();
		exp_q.push_back(ref_frame());
		send_cmd(OPC_START, 12'h000);
		check_val("sc_busy_o", 128'(sc_busy), 128'(0));
		step();
		check_val("sc_busy_o", 128'(sc_busy), 128'(1));
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_checked < target && n < FRAME_TIMEOUT)
		begin
			step();
			n++;
		end
		if (frames_checked < target)
			abort_run("Timeout while waiting for a frame to end with sc_done_o");
	endtask

	////////////////////////////////////////////////////////////
	// Capture, handshake monitor and compare
	////////////////////////////////////////////////////////////
	always @(negedge Clk_Out_2_All)
	begin
		if (!rst_n)
		begin
			ck_prev   = 1'b0;
			cap_frame = '0;
			cap_cnt   = 0;
		end
		else
		begin
			if (sr_ck && !ck_prev)   // First low phase after a serial rise
			begin
				cap_frame = {cap_frame[102:0], sr_in};
				cap_cnt   = cap_cnt + 1;
			end
			if (sc_done)
			begin
				cap_q.push_back(cap_frame);
				cnt_q.push_back(cap_cnt);
				cap_frame = '0;
				cap_cnt   = 0;
			end
			ck_prev = sr_ck;
		end
	end

	always @(negedge Clk_Out_2_All)
	begin
		if (!rst_n)
		begin
			busy_prev = 1'b0;
			done_prev = 1'b0;
		end
		else
		begin
			if (sc_done && done_prev)
				abort_run("sc_done_o stayed high for more than one cycle");
			else if (sc_done && !busy_prev)
				abort_run("sc_done_o pulsed while sc_busy_o was low");
			else if (busy_prev && !sc_busy && !sc_done)
				abort_run("sc_busy_o fell without an sc_done_o pulse");
			else if (sc_done)
				check_val("sc_busy_o with sc_done_o", 128'(sc_busy), 128'(0));
			busy_prev = sc_busy;
			done_prev = sc_done;
		end
	end

	always @(posedge Clk_Out_2_All)
	begin
		logic [103:0] got;
		logic [103:0] want;
		int           edges;
		if (!rst_n)
			frames_checked <= 0;
		else if (cap_q.size() > 0)
		begin
			got   = cap_q.pop_front();
			edges = cnt_q.pop_front();
			if (exp_q.size() == 0)
				abort_run("A frame finished on sc_done_o that no start asked for");
			else
			begin
				want = exp_q.pop_front();
				check_val("sr_ck_o rising edges", 128'(edges), 128'(FRAME_BITS));
				check_val("sr_in_o frame", 128'(got), 128'(want));
				frames_checked <= frames_checked + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial
	begin
		int         n;
		int         nw;
		int         sel;
		logic [3:0] op;
		cmd_word  = '0;
		cmd_valid = 1'b0;
		m_thr     = '0;
		m_gain    = '0;
		m_mask    = '0;
		m_fbcap   = '0;
		m_tdc     = 1'b0;
		m_adc     = 1'b0;
		m_chip    = 8'd1;
		void'($urandom(58));
		n = 0;
		while (rst_n !== 1'b1 && n < RST_TIMEOUT)
		begin
			step();
			n++;
		end
		if (rst_n !== 1'b1)
			abort_run("Reset was never released");
		step();

		// Quiet outputs, then the reset frame
		check_val("sr_ck_o", 128'(sr_ck), 128'(0));
		check_val("sr_in_o", 128'(sr_in), 128'(0));
		check_val("sc_busy_o", 128'(sc_busy), 128'(0));
		check_val("sc_done_o", 128'(sc_done), 128'(0));
		send_start();
		wait_frames(1);

		// Every field type, upper payload bits set where ignored
		send_cmd(OPC_THR_DAC, 12'hEA5);
		send_cmd(OPC_GAIN_DAC, 12'h55A);
		for (int i = 0; i < 8; i++)
			send_cmd(OPC_MASK_BYTE, {1'b1, 3'(i), 8'(i * 37 + 5)});
		send_cmd(OPC_FB_CAP, 12'hFF9);
		send_cmd(OPC_FLAGS, 12'hFF2);   // TDC on, ADC test off
		send_cmd(OPC_CHIP_ID, 12'hF5C);
		send_start();
		wait_frames(2);

		// Random rounds, each closed by a reserved opcode
		for (int r = 0; r < 20; r++)
		begin
			nw = 3 + int'($urandom_range(0, 5));
			for (int w = 0; w < nw; w++)
			begin
				sel = int'($urandom_range(0, 7));
				if (sel < 6)
					op = 4'(sel + 1);
				else if (sel == 6)
					op = OPC_MASK_BYTE;   // Mask bytes twice as often
				else
					op = unknown_opcode();
				send_cmd(op, 12'($urandom()));
			end
			send_cmd(unknown_opcode(), 12'($urandom()));
			send_start();
			wait_frames(3 + r);
		end

		// Writes and a second start while the frame is in flight
		send_start();
		send_cmd(OPC_CHIP_ID, 12'h0A7);
		send_cmd(OPC_THR_DAC, 12'h3C3);
		send_cmd(OPC_MASK_BYTE, 12'h7E1);
		send_cmd(OPC_START, 12'h000);   // Dropped by the packer
		check_val("sc_busy_o", 128'(sc_busy), 128'(1));
		wait_frames(23);
		for (int i = 0; i < 40; i++)
		begin
			step();
			check_val("sc_busy_o after frame", 128'(sc_busy), 128'(0));
			check_val("sr_ck_o after frame", 128'(sr_ck), 128'(0));
		end
		check_val("frames finished", 128'(frames_checked), 128'(23));
		send_start();   // Carries the values written during busy
		wait_frames(24);

		check_val("frames still expected", 128'(exp_q.size()), 128'(0));
		$display("Test OK");
		$finish;
	end

endmodule

// File: files.f
source/sc_cmd_pkg.sv
source/sc_frame_pkg.sv
source/sc_cmd_decoder.sv
source/sc_frame_packer.sv
source/sc_byte_fifo.sv
source/sc_serializer.sv
source/skiroc_sc_top.sv
dv/tb_clk_gen.sv
dv/tb_skiroc_sc.sv

// File: source/sc_byte_fifo.sv
/*
 * Synchronous byte FIFO
 * Circular buffer between the frame packer and the serializer, with
 * read and write pointers and an occupancy count. Read data shows up
 * one cycle after the read enable. Callers keep clear of full and empty.
 */
`timescale 1ns/1ns

module sc_byte_fifo #(
	parameter int FIFO_DEPTH = 16   // Power of two, at least 2
) (
	input  logic                   Clk_Out_2_All,
	input  logic                   rst_n_i,
	input  logic                   wr_en_i,
	input  sc_frame_pkg::sc_byte_t wr_data_i,
	input  logic                   rd_en_i,
	output sc_frame_pkg::sc_byte_t rd_data_o,
	output logic                   full_o,
	output logic                   empty_o
);

	import sc_frame_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
	begin : g_depth_check
		$error("sc_byte_fifo depth must be a power of two of at least 2");
	end

	sc_byte_t        mem [FIFO_DEPTH];
	logic [AW-1:0]   wr_ptr;   // Wraps naturally at the depth
	logic [AW-1:0]   rd_ptr;
	logic [AW:0]     count;    // One extra bit to hold a full count

	assign full_o  = (count == (AW+1)'(FIFO_DEPTH));
	assign empty_o = (count == '0);

	// Storage and read port
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (wr_en_i)
			mem[wr_ptr] <= wr_data_i;
		if (rd_en_i)
			rd_data_o <= mem[rd_ptr];
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en_i, rd_en_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	// Packer must hold off on full, serializer on empty
	a_no_write_full: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		wr_en_i |-> !full_o)
		else $error("byte FIFO written while full");

	a_no_read_empty: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		rd_en_i |-> !empty_o)
		else $error("byte FIFO read while empty");

endmodule

// File: source/sc_cmd_decoder.sv
/*
 * Slow-control command decoder
 * Takes one command word per strobe and updates the matching field of
 * the live configuration. A start opcode gives a one-cycle start pulse
 * on the next cycle. Unknown opcodes leave everything as it was.
 */
`timescale 1ns/1ns

module sc_cmd_decoder (
	input  logic                     Clk_Out_2_All,
	input  logic                     rst_n_i,
	input  sc_cmd_pkg::sc_cmd_t      cmd_i,
	input  logic                     cmd_valid_i,
	output sc_frame_pkg::sc_config_t cfg_o,
	output logic                     start_o
);

	import sc_cmd_pkg::*;
	import sc_frame_pkg::*;

	logic [MASK_IDX_W-1:0] mask_idx;   // Which mask byte a write hits

	assign mask_idx = cmd_i.payload[MASK_IDX_LSB +: MASK_IDX_W];

	////////////////////////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			cfg_o   <= CFG_RESET;
			start_o <= 1'b0;
		end
		else
		begin
			start_o <= 1'b0;   // Pulse only
			if (cmd_valid_i)
			begin
				case (cmd_i.opcode)
					OPC_THR_DAC:
					begin
						cfg_o.thr_dac <= cmd_i.payload[DAC_W-1:0];
					end
					OPC_GAIN_DAC:
					begin
						cfg_o.gain_dac <= cmd_i.payload[DAC_W-1:0];
					end
					OPC_MASK_BYTE:
					begin
						// Index 0 lands on mask bits 7..0
						cfg_o.mask[mask_idx*BYTE_W +: BYTE_W] <= cmd_i.payload[BYTE_W-1:0];
					end
					OPC_FB_CAP:
					begin
						cfg_o.fb_cap <= cmd_i.payload[FBCAP_W-1:0];
					end
					OPC_FLAGS:
					begin
						cfg_o.tdc_on   <= cmd_i.payload[FLAG_TDC_BIT];
						cfg_o.adc_test <= cmd_i.payload[FLAG_ADC_BIT];
					end
					OPC_CHIP_ID:
					begin
						cfg_o.chip_id <= cmd_i.payload[CHIPID_W-1:0];
					end
					OPC_START:
					begin
						start_o <= 1'b1;   // Packer decides if it is taken
					end
					default:
					begin
						// Reserved opcodes, nothing changes
					end
				endcase
			end
		end
	end

endmodule

// File: source/sc_cmd_pkg.sv
/*
 * Slow-control command word definitions
 * A 16-bit word from the USB controller carries a 4-bit opcode on top
 * and a 12-bit payload below it. The opcode selects which configuration
 * field the payload updates, or starts a configuration cycle.
 */
package sc_cmd_pkg;

	////////////////////////////////////////////////////////////
	// Word layout
	////////////////////////////////////////////////////////////
	localparam int CMD_W = 16;             // Full command word
	localparam int OPC_W = 4;              // Opcode in the upper bits
	localparam int PAY_W = CMD_W - OPC_W;  // Payload below the opcode

	// Mask byte write, byte index above the byte itself
	localparam int MASK_IDX_LSB = 8;
	localparam int MASK_IDX_W   = 3;       // Eight bytes of mask

	// Flag bits inside the OPC_FLAGS payload
	localparam int FLAG_TDC_BIT = 1;
	localparam int FLAG_ADC_BIT = 0;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////
	typedef enum logic [OPC_W-1:0] {
		OPC_THR_DAC   = 4'd1,   // Threshold DAC
		OPC_GAIN_DAC  = 4'd2,   // Gain DAC
		OPC_MASK_BYTE = 4'd3,   // One byte of the channel mask
		OPC_FB_CAP    = 4'd4,   // Feedback capacitance
		OPC_FLAGS     = 4'd5,   // TDC on and ADC test
		OPC_CHIP_ID   = 4'd6,   // Chip ID
		OPC_START     = 4'd15   // Ship the configuration out
	} sc_opcode_t;

	// One command word as it leaves the USB controller
	typedef struct packed {
		sc_opcode_t       opcode;
		logic [PAY_W-1:0] payload;
	} sc_cmd_t;

endpackage

// File: source/sc_frame_packer.sv
/*
 * Slow-control frame packer
 * Snapshots the live configuration on an accepted start and writes it
 * into the byte FIFO, most significant byte first, one byte per cycle
 * while the FIFO has room. Owns the busy flag, which drops together
 * with the serializer's done pulse.
 */
`timescale 1ns/1ns

module sc_frame_packer (
	input  logic                     Clk_Out_2_All,
	input  logic                     rst_n_i,
	input  sc_frame_pkg::sc_config_t cfg_i,
	input  logic                     start_i,
	input  logic                     fifo_full_i,
	output logic                     fifo_wr_en_o,
	output sc_frame_pkg::sc_byte_t   fifo_wr_data_o,
	output logic                     frame_done_o,
	input  logic                     ser_done_i,
	output logic                     busy_o
);

	import sc_frame_pkg::*;

	localparam int CNT_W = $clog2(FRAME_BYTES);

	logic [FRAME_BITS-1:0] frame_q;    // Frame in flight
	logic [CNT_W-1:0]      byte_cnt;   // Next byte to write
	logic                  busy_r;
	logic                  fill_r;     // Still bytes left to write
	logic                  accept;

	assign accept         = start_i && !busy_r;   // Starts during busy are dropped
	assign fifo_wr_en_o   = fill_r && !fifo_full_i;
	assign fifo_wr_data_o = frame_q[FRAME_BITS-1 - BYTE_W*byte_cnt -: BYTE_W];
	assign busy_o         = busy_r && !ser_done_i;   // Falls on the done edge

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (accept)
			frame_q <= cfg_i;   // Later field writes do not reach this frame
	end

	////////////////////////////////////////////////////////////
	// Busy and byte sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			busy_r       <= 1'b0;
			fill_r       <= 1'b0;
			byte_cnt     <= '0;
			frame_done_o <= 1'b0;
		end
		else
		begin
			frame_done_o <= 1'b0;
			if (accept)
			begin
				busy_r   <= 1'b1;
				fill_r   <= 1'b1;
				byte_cnt <= '0;
			end
			else if (fifo_wr_en_o)
			begin
				if (byte_cnt == CNT_W'(FRAME_BYTES-1))
				begin
					fill_r       <= 1'b0;   // Last byte goes in now
					frame_done_o <= 1'b1;
				end
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
			else if (ser_done_i)
				busy_r <= 1'b0;
		end
	end

	// Serializer may only finish a frame that was fully written
	a_done_after_fill: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		ser_done_i |-> busy_r && !fill_r)
		else $error("serializer done before the packer wrote its whole frame");

endmodule

// File: source/sc_frame_pkg.sv
/*
 * Slow-control frame definitions
 * Field types of the SKIROC2 configuration, the packed frame that is
 * shifted into the chip MSB first, and its size in bits and bytes.
 */
package sc_frame_pkg;

	////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////
	localparam int DAC_W    = 10;
	localparam int MASK_W   = 64;   // One bit per channel
	localparam int FBCAP_W  = 4;
	localparam int CHIPID_W = 8;
	localparam int BYTE_W   = 8;

	localparam int FRAME_BITS  = 104;
	localparam int FRAME_BYTES = FRAME_BITS / BYTE_W;   // 13 bytes per frame

	// Filler that rounds the frame up to whole bytes
	localparam int PAD_W = FRAME_BITS - CHIPID_W - MASK_W - 2*DAC_W - FBCAP_W - 2;

	typedef logic [DAC_W-1:0]    sc_dac_t;
	typedef logic [MASK_W-1:0]   sc_mask_t;
	typedef logic [FBCAP_W-1:0]  sc_fbcap_t;
	typedef logic [CHIPID_W-1:0] sc_chipid_t;
	typedef logic [BYTE_W-1:0]   sc_byte_t;     // One frame byte in the FIFO

	////////////////////////////////////////////////////////////
	// Frame, MSB goes out first
	////////////////////////////////////////////////////////////
	typedef struct packed {
		sc_chipid_t       chip_id;    // Bits 103..96
		sc_mask_t         mask;       // Bits 95..32
		sc_dac_t          thr_dac;
		sc_dac_t          gain_dac;
		sc_fbcap_t        fb_cap;
		logic             tdc_on;
		logic             adc_test;
		logic [PAD_W-1:0] pad;        // Always zero
	} sc_config_t;

	// Power-up configuration, chip 1 with everything else off
	localparam sc_config_t CFG_RESET = '{
		chip_id:  sc_chipid_t'(1),
		mask:     '0,
		thr_dac:  '0,
		gain_dac: '0,
		fb_cap:   '0,
		tdc_on:   1'b0,
		adc_test: 1'b0,
		pad:      '0
	};

endpackage

// File: source/sc_serializer.sv
/*
 * Slow-control serializer
 * Pulls bytes from the FIFO and shifts them out MSB first on the
 * sr_ck/sr_in pair. Data changes with the clock low, the chip samples
 * on the rising edge. The clock parks low while the FIFO runs dry.
 * After FRAME_BITS bits and the packer's frame_done it pulses done.
 */
`timescale 1ns/1ns

module sc_serializer #(
	parameter int SR_HALF_PERIOD = 3   // Cycles per half serial clock
) (
	input  logic                   Clk_Out_2_All,
	input  logic                   rst_n_i,
	input  logic                   frame_done_i,
	input  logic                   fifo_empty_i,
	output logic                   fifo_rd_en_o,
	input  sc_frame_pkg::sc_byte_t fifo_rd_data_i,
	output logic                   sr_ck_o,
	output logic                   sr_in_o,
	output logic                   done_o
);

	import sc_frame_pkg::*;

	localparam int HP_W = $clog2(SR_HALF_PERIOD + 1);
	localparam int BC_W = $clog2(FRAME_BITS + 1);

	typedef enum logic [2:0] {
		ST_IDLE,   // No frame in progress
		ST_LOAD,   // FIFO data valid this cycle
		ST_LOW,    // Clock low, data settling
		ST_HIGH,   // Clock high, chip has sampled
		ST_WAIT,   // Mid-frame, FIFO empty
		ST_END     // All bits out, waiting on packer
	} ser_state_t;

	ser_state_t       state_q;
	sc_byte_t         shreg;        // Current byte, bit 7 on the line
	logic [HP_W-1:0]  hp_cnt;
	logic [2:0]       bit_idx;      // Bit within the byte
	logic [BC_W-1:0]  bit_cnt;      // Bits sent in this frame
	logic             frame_seen;   // Packer has written its last byte
	logic             hp_end;

	assign hp_end       = (hp_cnt == HP_W'(SR_HALF_PERIOD - 1));
	assign fifo_rd_en_o = (state_q == ST_IDLE || state_q == ST_WAIT) && !fifo_empty_i;

	// Byte shifter
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (state_q == ST_LOAD)
			shreg <= fifo_rd_data_i;
		else if (state_q == ST_HIGH && hp_end)
			shreg <= {shreg[BYTE_W-2:0], 1'b0};
	end

	////////////////////////////////////////////////////////////
	// Bit timing FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!rst_n_i)
		begin
			state_q    <= ST_IDLE;
			hp_cnt     <= '0;
			bit_idx    <= '0;
			bit_cnt    <= '0;
			frame_seen <= 1'b0;
			sr_ck_o    <= 1'b0;
			sr_in_o    <= 1'b0;
			done_o     <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (frame_done_i)
				frame_seen <= 1'b1;
			case (state_q)
				ST_IDLE, ST_WAIT:
				begin
					if (!fifo_empty_i)
						state_q <= ST_LOAD;   // rd_en goes out this cycle
				end
				ST_LOAD:
				begin
					sr_in_o <= fifo_rd_data_i[BYTE_W-1];   // MSB first
					bit_idx <= '0;
					hp_cnt  <= '0;
					state_q <= ST_LOW;
				end
				ST_LOW:
				begin
					if (hp_end)
					begin
						hp_cnt  <= '0;
						sr_ck_o <= 1'b1;   // Rising edge, chip samples
						state_q <= ST_HIGH;
					end
					else
						hp_cnt <= hp_cnt + 1'b1;
				end
				ST_HIGH:
				begin
					if (hp_end)
					begin
						hp_cnt  <= '0;
						sr_ck_o <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_idx == 3'd7)
						begin
							if (bit_cnt == BC_W'(FRAME_BITS - 1))
								state_q <= ST_END;
							else
								state_q <= ST_WAIT;
						end
						else
						begin
							bit_idx <= bit_idx + 1'b1;
							sr_in_o <= shreg[BYTE_W-2];   // Next bit with clock going low
							state_q <= ST_LOW;
						end
					end
					else
						hp_cnt <= hp_cnt + 1'b1;
				end
				ST_END:
				begin
					if (frame_seen)
					begin
						done_o     <= 1'b1;
						frame_seen <= 1'b0;
						bit_cnt    <= '0;
						sr_in_o    <= 1'b0;   // Line back to rest
						state_q    <= ST_IDLE;
					end
				end
				default:
				begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	a_ck_low_idle: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		state_q == ST_IDLE |-> !sr_ck_o)
		else $error("serial clock high while serializer idle");

	// Data must already be settled when the chip samples
	a_data_stable_rise: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		$rose(sr_ck_o) |-> $stable(sr_in_o))
		else $error("serial data moved on the rising clock edge");

endmodule

// File: source/skiroc_sc_top.sv
/*
 * SKIROC2 slow-control path
 * Command decoder, frame packer, byte FIFO and serializer in a chain,
 * from USB command words to the chip's serial configuration pins.
 */
`timescale 1ns/1ns

module skiroc_sc_top #(
	parameter int SR_HALF_PERIOD = 3,    // Serial clock half period in cycles
	parameter int FIFO_DEPTH     = 16    // Byte FIFO depth
) (
	input  logic                Clk_Out_2_All,
	input  logic                rst_n_i,
	input  sc_cmd_pkg::sc_cmd_t cmd_i,
	input  logic                cmd_valid_i,
	output logic                sr_ck_o,
	output logic                sr_in_o,
	output logic                sc_busy_o,
	output logic                sc_done_o
);

	import sc_frame_pkg::*;

	sc_config_t cfg;           // Live configuration
	logic       start;
	logic       fifo_full;
	logic       fifo_wr_en;
	sc_byte_t   fifo_wr_data;
	logic       fifo_rd_en;
	sc_byte_t   fifo_rd_data;
	logic       fifo_empty;
	logic       frame_done;    // Packer has written all bytes

	////////////////////////////////////////////////////////////
	// Command side
	////////////////////////////////////////////////////////////
	sc_cmd_decoder u_decoder (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.cfg_o         (cfg),
		.start_o       (start)
	);

	sc_frame_packer u_packer (
		.Clk_Out_2_All  (Clk_Out_2_All),
		.rst_n_i        (rst_n_i),
		.cfg_i          (cfg),
		.start_i        (start),
		.fifo_full_i    (fifo_full),
		.fifo_wr_en_o   (fifo_wr_en),
		.fifo_wr_data_o (fifo_wr_data),
		.frame_done_o   (frame_done),
		.ser_done_i     (sc_done_o),     // Busy ends with the last bit
		.busy_o         (sc_busy_o)
	);

	////////////////////////////////////////////////////////////
	// Chip side
	////////////////////////////////////////////////////////////
	sc_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.wr_en_i       (fifo_wr_en),
		.wr_data_i     (fifo_wr_data),
		.rd_en_i       (fifo_rd_en),
		.rd_data_o     (fifo_rd_data),
		.full_o        (fifo_full),
		.empty_o       (fifo_empty)
	);

	sc_serializer #(
		.SR_HALF_PERIOD (SR_HALF_PERIOD)
	) u_serializer (
		.Clk_Out_2_All  (Clk_Out_2_All),
		.rst_n_i        (rst_n_i),
		.frame_done_i   (frame_done),
		.fifo_empty_i   (fifo_empty),
		.fifo_rd_en_o   (fifo_rd_en),
		.fifo_rd_data_i (fifo_rd_data),
		.sr_ck_o        (sr_ck_o),
		.sr_in_o        (sr_in_o),
		.done_o         (sc_done_o)
	);

endmodule
